//--- hw/tlul_pkg.sv
`default_nettype none

package tlul_pkg;

    // ----------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------
    parameter int TL_DW  = 32;            // Data width
    parameter int TL_AW  = 32;            // Byte address width
    parameter int TL_SZW = 2;             // log2 of transfer bytes
    parameter int TL_AIW = 1;             // Source id width
    parameter int TL_DBW = TL_DW / 8;     // Byte lanes, also mask width

    // ----------------------------------------------------------
    // Field widths
    // ----------------------------------------------------------
    parameter int TL_OPW = 3;             // A and D opcode field
    parameter int TL_PW  = 3;             // a_param, always zero in TL-UL

    // A channel opcodes, TL-UL subset
    typedef enum logic [TL_OPW-1:0] {
        PutFullData    = 3'h0,            // All mask bits set
        PutPartialData = 3'h1,            // Any mask pattern
        Get            = 3'h4
    } tl_a_op_e;

    // D channel opcodes
    typedef enum logic [TL_OPW-1:0] {
        AccessAck     = 3'h0,             // Answer to a put
        AccessAckData = 3'h1              // Answer to a get, carries data
    } tl_d_op_e;

endpackage

`default_nettype wire

//--- hw/intg_pkg.sv
`default_nettype none

package intg_pkg;

    // ----------------------------------------------------------
    // Integrity widths
    // ----------------------------------------------------------
    parameter int H2DCmdIntgWidth = 7;    // Over address, opcode, mask, instr type
    parameter int DataIntgWidth   = 7;    // Over A channel data

    // a_user layout, MSB first: pad, instr type, cmd intg, data intg
    parameter int AUserPadW     = 5;
    parameter int InstrTypeW    = 4;
    parameter int AUserDataLsb  = 0;
    parameter int AUserCmdLsb   = AUserDataLsb + DataIntgWidth;
    parameter int AUserInstrLsb = AUserCmdLsb + H2DCmdIntgWidth;
    parameter int TL_AUW        = AUserPadW + InstrTypeW + H2DCmdIntgWidth + DataIntgWidth;

    // Multibit boolean, only two legal codes
    typedef logic [InstrTypeW-1:0] mubi4_t;

    parameter mubi4_t MuBi4True  = 4'h6;  // Instruction fetch
    parameter mubi4_t MuBi4False = 4'h9;  // Data access

endpackage

`default_nettype wire

//--- hw/tl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface tl_if;
    import tlul_pkg::*;
    import intg_pkg::*;

    // A channel, host to device
    logic              a_valid;
    tl_a_op_e          a_opcode;
    logic [TL_PW-1:0]  a_param;
    logic [TL_SZW-1:0] a_size;
    logic [TL_AIW-1:0] a_source;
    logic [TL_AW-1:0]  a_address;     // Byte address
    logic [TL_DBW-1:0] a_mask;
    logic [TL_DW-1:0]  a_data;
    logic [TL_AUW-1:0] a_user;        // Instr type and integrity
    logic              a_ready;

    // D channel, device to host
    logic              d_valid;
    tl_d_op_e          d_opcode;
    logic [TL_AIW-1:0] d_source;      // Echo of a_source
    logic [TL_DW-1:0]  d_data;
    logic              d_error;
    logic              d_ready;       // Tied to d_valid by the host

    modport host (
        output a_valid, a_opcode, a_param, a_size, a_source,
        output a_address, a_mask, a_data, a_user, d_ready,
        input  a_ready, d_valid, d_opcode, d_source, d_data, d_error
    );

    modport device (
        input  a_valid, a_opcode, a_param, a_size, a_source,
        input  a_address, a_mask, a_data, a_user, d_ready,
        output a_ready, d_valid, d_opcode, d_source, d_data, d_error
    );

endinterface

`default_nettype wire

//--- hw/tl_intg_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tl_intg_gen #(
    parameter int AW = 32,                                  // Address bits folded in
    parameter int DW = 32                                   // Data bits folded in
) (
    input  intg_pkg::mubi4_t                      instr_type_i,
    input  logic [AW-1:0]                         addr_i,
    input  tlul_pkg::tl_a_op_e                    opcode_i,
    input  logic [DW/8-1:0]                       mask_i,
    input  logic [DW-1:0]                         data_i,
    output logic [intg_pkg::H2DCmdIntgWidth-1:0]  cmd_intg_o,
    output logic [intg_pkg::DataIntgWidth-1:0]    data_intg_o
);
    import tlul_pkg::*;
    import intg_pkg::*;

    localparam int CmdW = AW + TL_OPW + DW/8 + InstrTypeW;

    logic [CmdW-1:0] cmd_field;

    // Command field, instr type sits in the low bits
    assign cmd_field = {addr_i, opcode_i, mask_i, instr_type_i};

    // ----------------------------------------------------------
    // XOR fold, bit i collects every input bit with index mod W == i
    // ----------------------------------------------------------
    always_comb begin
        cmd_intg_o = '0;
        for (int i = 0; i < CmdW; i++) begin
            cmd_intg_o[i % H2DCmdIntgWidth] ^= cmd_field[i];
        end
    end

    always_comb begin
        data_intg_o = '0;
        for (int i = 0; i < DW; i++) begin
            data_intg_o[i % DataIntgWidth] ^= data_i[i];   // Zero data for reads
        end
    end

endmodule

`default_nettype wire

//--- hw/sub2tlul.sv
`timescale 1ns/10ps
`default_nettype none

module sub2tlul #(
    parameter int AW = 32,                   // Component address width
    parameter int DW = 32,                   // Component data width, same as TL_DW
    parameter int IW = 1                     // Component id width
) (
    input  logic            clk,
    input  logic            rst_n,

    // Component side
    input  logic            dv_i,            // Beat valid
    input  logic [AW-1:0]   addr_i,          // Byte address
    input  logic            write_i,
    input  logic [IW-1:0]   id_i,
    input  logic [DW-1:0]   wdata_i,
    input  logic [DW/8-1:0] wstrb_i,
    input  logic [2:0]      size_i,
    output logic [DW-1:0]   rdata_o,
    output logic            hld_o,           // Component must stall
    output logic            rd_err_o,
    output logic            wr_err_o,

    // TL-UL host side
    tl_if.host              tl
);
    import tlul_pkg::*;
    import intg_pkg::*;

    localparam mubi4_t InstrType = MuBi4False;   // Data accesses only

    typedef enum logic [1:0] {
        TxnNone = 2'b00,
        TxnGet  = 2'b01,
        TxnPut  = 2'b10
    } txn_state_e;

    txn_state_e                 cur_txn;
    logic                       pending_txn;     // A sent, D not back yet
    tl_a_op_e                   opcode;
    logic [DW/8-1:0]            mask_local;
    logic [DW-1:0]              data_local;
    logic [H2DCmdIntgWidth-1:0] cmd_intg;
    logic [DataIntgWidth-1:0]   data_intg;
    logic                       a_fire;
    logic                       rsp_get;         // Read answered as expected
    logic                       rsp_put;         // Write answered as expected

    // ----------------------------------------------------------
    // Request build
    // ----------------------------------------------------------
    assign opcode     = !write_i ? Get : ((wstrb_i == '1) ? PutFullData : PutPartialData);
    assign mask_local = !write_i ? '1 : wstrb_i;          // Reads fetch the whole word
    assign data_local = !write_i ? '0 : wdata_i;

    // Folded over the full TL-UL address, as the device sees it
    tl_intg_gen #(
        .AW (TL_AW),
        .DW (DW)
    ) u_tl_intg_gen (
        .instr_type_i (InstrType),
        .addr_i       (TL_AW'(addr_i)),
        .opcode_i     (opcode),
        .mask_i       (mask_local),
        .data_i       (data_local),
        .cmd_intg_o   (cmd_intg),
        .data_intg_o  (data_intg)
    );

    assign tl.a_valid   = dv_i & ~pending_txn;          // One transaction in flight
    assign tl.a_opcode  = opcode;
    assign tl.a_param   = '0;
    assign tl.a_size    = size_i[TL_SZW-1:0];
    assign tl.a_source  = TL_AIW'(id_i);
    assign tl.a_address = TL_AW'(addr_i);
    assign tl.a_mask    = mask_local;
    assign tl.a_data    = data_local;
    assign tl.a_user    = {{AUserPadW{1'b0}}, InstrType, cmd_intg, data_intg};
    assign tl.d_ready   = tl.d_valid;                   // Never back-pressure D

    assign a_fire = tl.a_valid & tl.a_ready;

    // ----------------------------------------------------------
    // Transaction tracking
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_txn     <= TxnNone;
            pending_txn <= 1'b0;
        end else if (a_fire) begin
            cur_txn     <= (opcode == Get) ? TxnGet : TxnPut;
            pending_txn <= 1'b1;
        end else if (tl.d_valid) begin                  // Any response ends it
            cur_txn     <= TxnNone;
            pending_txn <= 1'b0;
        end
    end

    // Response kind must match the request kind
    assign rsp_get = tl.d_valid & (cur_txn == TxnGet) & (tl.d_opcode == AccessAckData);
    assign rsp_put = tl.d_valid & (cur_txn == TxnPut) & (tl.d_opcode == AccessAck);

    // ----------------------------------------------------------
    // Component response, valid in the D cycle only
    // ----------------------------------------------------------
    assign rdata_o  = (rsp_get && tl.d_source == TL_AIW'(id_i)) ? tl.d_data : '0;
    assign hld_o    = dv_i & ~tl.d_valid;               // Stall until the answer
    assign rd_err_o = ~write_i & tl.d_valid & (tl.d_error | ~rsp_get);
    assign wr_err_o =  write_i & tl.d_valid & (tl.d_error | ~rsp_put);

endmodule

`default_nettype wire

//--- hw/tl_mem_dev.sv
`timescale 1ns/10ps
`default_nettype none

module tl_mem_dev #(
    parameter int MEM_DEPTH = 64,             // Words
    parameter int RSP_LAT   = 2               // A transfer to d_valid, 1 or more
) (
    input  logic clk,
    input  logic rst_n,
    tl_if.device tl
);
    import tlul_pkg::*;
    import intg_pkg::*;

    localparam int BoffW = $clog2(TL_DBW);                 // Byte offset bits
    localparam int WaW   = TL_AW - BoffW;                  // Word address bits
    localparam int IdxW  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;
    localparam int CntW  = $clog2(RSP_LAT + 1);

    logic [TL_DW-1:0]           mem [MEM_DEPTH];
    logic                       busy;                      // Request accepted, no D yet
    logic [CntW-1:0]            cnt;                       // Cycles left to D
    logic [WaW-1:0]             word_addr;
    logic [IdxW-1:0]            idx;
    mubi4_t                     instr_type;
    logic [H2DCmdIntgWidth-1:0] cmd_intg_exp;
    logic [DataIntgWidth-1:0]   data_intg_exp;
    logic                       intg_err;
    logic                       range_err;
    logic                       req_err;
    logic                       a_fire;
    tl_d_op_e                   rsp_opcode;
    logic [TL_AIW-1:0]          rsp_source;
    logic [TL_DW-1:0]           rsp_data;
    logic                       rsp_error;

    // ----------------------------------------------------------
    // Request check
    // ----------------------------------------------------------
    assign word_addr  = tl.a_address[TL_AW-1:BoffW];
    assign idx        = word_addr[IdxW-1:0];
    assign instr_type = tl.a_user[AUserInstrLsb +: InstrTypeW];

    // Recompute over what actually arrived
    tl_intg_gen #(
        .AW (TL_AW),
        .DW (TL_DW)
    ) u_tl_intg_gen (
        .instr_type_i (instr_type),
        .addr_i       (tl.a_address),
        .opcode_i     (tl.a_opcode),
        .mask_i       (tl.a_mask),
        .data_i       (tl.a_data),
        .cmd_intg_o   (cmd_intg_exp),
        .data_intg_o  (data_intg_exp)
    );

    // Malformed instr type counts as an integrity failure
    assign intg_err = (tl.a_user[AUserCmdLsb +: H2DCmdIntgWidth] != cmd_intg_exp)
                    | (tl.a_user[AUserDataLsb +: DataIntgWidth] != data_intg_exp)
                    | ((instr_type != MuBi4True) && (instr_type != MuBi4False));
    assign range_err = (word_addr >= WaW'(MEM_DEPTH));
    assign req_err   = intg_err | range_err;

    assign tl.a_ready = ~busy;                             // Ready whenever idle
    assign a_fire     = tl.a_valid & ~busy;

    // ----------------------------------------------------------
    // Storage, write lands at the A transfer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < MEM_DEPTH; w++) begin
                mem[w] <= '0;
            end
        end else if (a_fire && !req_err && tl.a_opcode != Get) begin
            for (int b = 0; b < TL_DBW; b++) begin
                if (tl.a_mask[b]) begin
                    mem[idx][8*b +: 8] <= tl.a_data[8*b +: 8];   // Byte lane merge
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Response timing
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (a_fire) begin
            busy <= 1'b1;
            cnt  <= CntW'(RSP_LAT - 1);                    // Hits zero in the D cycle
        end else if (busy) begin
            if (cnt == '0) begin
                busy <= 1'b0;                              // D sent, d_ready follows it
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // Response payload, captured with the request
    always_ff @(posedge clk) begin
        if (a_fire) begin
            rsp_source <= tl.a_source;
            rsp_opcode <= (tl.a_opcode == Get) ? AccessAckData : AccessAck;
            rsp_data   <= (req_err || tl.a_opcode != Get) ? '0 : mem[idx];
            rsp_error  <= req_err;
        end
    end

    assign tl.d_valid  = busy & (cnt == '0);
    assign tl.d_opcode = rsp_opcode;
    assign tl.d_source = rsp_source;
    assign tl.d_data   = rsp_data;
    assign tl.d_error  = rsp_error;

endmodule

`default_nettype wire

//--- hw/sub_tl_top.sv
`timescale 1ns/10ps
`default_nettype none

module sub_tl_top #(
    parameter int AW        = 32,             // Component address width
    parameter int DW        = 32,             // Must match the TL-UL data width
    parameter int IW        = 1,
    parameter int MEM_DEPTH = 64,             // Device words
    parameter int RSP_LAT   = 2               // Device response latency
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dv_i,
    input  logic [AW-1:0]   addr_i,
    input  logic            write_i,
    input  logic [IW-1:0]   id_i,
    input  logic [DW-1:0]   wdata_i,
    input  logic [DW/8-1:0] wstrb_i,
    input  logic [2:0]      size_i,
    output logic [DW-1:0]   rdata_o,
    output logic            hld_o,
    output logic            rd_err_o,
    output logic            wr_err_o
);

    tl_if tl ();                              // Bridge to device link

    // Component beats in, TL-UL out
    sub2tlul #(
        .AW (AW),
        .DW (DW),
        .IW (IW)
    ) u_sub2tlul (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .addr_i   (addr_i),
        .write_i  (write_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o),
        .tl       (tl.host)
    );

    tl_mem_dev #(
        .MEM_DEPTH (MEM_DEPTH),
        .RSP_LAT   (RSP_LAT)
    ) u_tl_mem_dev (
        .clk   (clk),
        .rst_n (rst_n),
        .tl    (tl.device)
    );

endmodule

`default_nettype wire

//--- test/sub_tl_properties.sv
`timescale 1ns/10ps
`default_nettype none

module sub_tl_properties #(
    parameter int RSP_LAT = 2
) (
    input logic clk,
    input logic rst_n,
    input logic dv_i,
    input logic hld_i,
    input logic a_valid_i,
    input logic a_ready_i,
    input logic d_valid_i
);

    logic               pend_q;                     // A accepted, D not seen yet
    logic [RSP_LAT-1:0] fire_q;                     // A transfer history, one bit per cycle
    int                 pend_fail = 0;
    int                 dlat_fail = 0;
    int                 hld_fail  = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            fire_q <= '0;
        end else begin
            fire_q <= (fire_q << 1) | RSP_LAT'(a_valid_i & a_ready_i);
            if (a_valid_i && a_ready_i) begin
                pend_q <= 1'b1;
            end else if (d_valid_i) begin
                pend_q <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------
    // Channel rules
    // ----------------------------------------------------------
    a_no_second_req: assert property (@(posedge clk) disable iff (!rst_n)
        pend_q |-> !a_valid_i) else begin
        $error("a_valid raised while a response is pending");
        pend_fail++;
    end

    // d_valid exactly RSP_LAT cycles after each A transfer, never otherwise
    a_rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        d_valid_i == fire_q[RSP_LAT-1]) else begin
        $error("d_valid out of step with the A transfer");
        dlat_fail++;
    end

    a_hld_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !dv_i |-> !hld_i) else begin
        $error("hld_o high with dv_i low");
        hld_fail++;
    end

endmodule

`default_nettype wire

//--- test/sub_tl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sub_tl_tb;

    localparam int    RSP_LAT      = 2;             // Same as the DUT default
    localparam int    CLK_PERIOD   = 8;
    localparam int    DRIVE_DLY    = 1;             // Inputs change this long after posedge
    localparam int    RESET_CYCLES = 10;
    localparam int    NUM_VEC      = 16;            // Lines in the stimulus file
    localparam int    FIELDS       = 9;             // Hex words per line
    localparam int    WATCHDOG_CYC = NUM_VEC * (RSP_LAT + 6) + RESET_CYCLES + 2;
    localparam string STIM_FILE    = "test/sub_tl_stimulus.txt";
    localparam logic [31:0] SEED   = 32'ha0cf_532b;

    logic        clk;
    logic        rst_n;
    logic        dv_i;
    logic [31:0] addr_i;
    logic        write_i;
    logic [0:0]  id_i;
    logic [31:0] wdata_i;
    logic [3:0]  wstrb_i;
    logic [2:0]  size_i;
    logic [31:0] rdata_o;
    logic        hld_o;
    logic        rd_err_o;
    logic        wr_err_o;

    logic [31:0] vec_mem [NUM_VEC*FIELDS];          // Flat copy of the stimulus file
    int          data_errs = 0;
    int          lat_errs  = 0;

    sub_tl_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .addr_i   (addr_i),
        .write_i  (write_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o)
    );

    // Channel checks sit inside every top instance
    bind sub_tl_top sub_tl_properties #(.RSP_LAT(RSP_LAT)) u_props (
        .clk       (clk),
        .rst_n     (rst_n),
        .dv_i      (dv_i),
        .hld_i     (hld_o),
        .a_valid_i (tl.a_valid),
        .a_ready_i (tl.a_ready),
        .d_valid_i (tl.d_valid)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // ----------------------------------------------------------
    // One beat: drive, wait out hld_o, check in the done cycle
    // ----------------------------------------------------------
    task automatic run_beat(input int n);
        int base;
        int lat;
        base    = n * FIELDS;
        write_i = vec_mem[base][0];
        addr_i  = vec_mem[base+1];
        wdata_i = vec_mem[base+2];
        wstrb_i = vec_mem[base+3][3:0];
        size_i  = vec_mem[base+4][2:0];
        id_i    = vec_mem[base+5][0:0];
        dv_i    = 1'b1;
        lat     = 0;
        @(negedge clk);                              // Outputs settled mid cycle
        while (hld_o) begin
            lat++;
            @(negedge clk);
        end
        assert (lat == RSP_LAT) else begin
            $display("Mismatch beat %0d latency: got %0h expected %0h", n, lat, RSP_LAT);
            lat_errs++;
        end
        assert (rdata_o == vec_mem[base+6]) else begin
            $display("Mismatch beat %0d rdata_o: got %08h expected %08h",
                     n, rdata_o, vec_mem[base+6]);
            data_errs++;
        end
        assert (rd_err_o == vec_mem[base+7][0]) else begin
            $display("Mismatch beat %0d rd_err_o: got %0h expected %0h",
                     n, rd_err_o, vec_mem[base+7][0]);
            data_errs++;
        end
        assert (wr_err_o == vec_mem[base+8][0]) else begin
            $display("Mismatch beat %0d wr_err_o: got %0h expected %0h",
                     n, wr_err_o, vec_mem[base+8][0]);
            data_errs++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        dv_i = 1'b0;                                 // Beat done, bus goes idle
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : main
        logic [31:0] seed;
        int          gap;
        int          prop_errs;
        clk     = 1'b0;
        rst_n   = 1'b0;
        dv_i    = 1'b0;
        addr_i  = '0;
        write_i = 1'b0;
        id_i    = '0;
        wdata_i = '0;
        wstrb_i = '0;
        size_i  = '0;
        seed    = SEED;
        $readmemh(STIM_FILE, vec_mem);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        for (int n = 0; n < NUM_VEC; n++) begin
            seed = lcg_next(seed);
            gap  = int'(seed[31:30]);                // 0 to 3 idle cycles
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DLY;
            end
            run_beat(n);
        end
        repeat (2) @(posedge clk);                   // Let the last property samples land
        prop_errs = dut.u_props.pend_fail + dut.u_props.dlat_fail + dut.u_props.hld_fail;
        $display("Errors: data %0d, latency %0d, assertion %0d",
                 data_errs, lat_errs, prop_errs);
        if (data_errs + lat_errs + prop_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Timeout: beats did not finish within %0d cycles", WATCHDOG_CYC);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/sub_tl_stimulus.txt
// write addr wdata wstrb size id exp_rdata exp_rd_err exp_wr_err
// All hex, byte addresses, device holds 64 words (0x00 to 0xfc)
0 00000010 00000000 0 2 0 00000000 0 0
1 00000010 deadbeef f 2 1 00000000 0 0
0 00000010 00000000 0 2 1 deadbeef 0 0
1 00000024 11223344 f 2 0 00000000 0 0
1 00000024 aabbccdd 5 2 0 00000000 0 0
0 00000024 00000000 0 2 0 11bb33dd 0 0
1 00000024 0000ee00 2 2 1 00000000 0 0
0 00000024 00000000 0 2 1 11bbeedd 0 0
0 00000100 00000000 0 2 0 00000000 1 0
1 00000100 cafef00d f 2 0 00000000 0 1
0 00000000 00000000 0 2 0 00000000 0 0
1 000001fc 12345678 f 2 1 00000000 0 1
0 000000fc 00000000 0 2 1 00000000 0 0
1 000000fc 0badf00d f 2 0 00000000 0 0
0 000000fc 00000000 0 2 0 0badf00d 0 0
0 00000010 00000000 0 2 1 deadbeef 0 0

//--- compile.f
hw/tlul_pkg.sv
hw/intg_pkg.sv
hw/tl_if.sv
hw/tl_intg_gen.sv
hw/sub2tlul.sv
hw/tl_mem_dev.sv
hw/sub_tl_top.sv
test/sub_tl_properties.sv
test/sub_tl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sub2tlul bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --top-module sub_tl_tb \
    -f compile.f -o sim_sub_tl > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

# Keep running after an assertion error so the testbench can give its verdict
./obj_dir/sim_sub_tl +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" "$SIM_LOG"; then
    exit 0
fi
exit 1
